/* sim/dq_testdata.hex */
// word 0 is the record count; each record: up_cfg down_cfg n_rcv n_q n_beats,
// then rcv words, expected halves, accelerator halves, beat data/last pairs
00000004
// record 1: 8 bit both ways, scale 0
01000004 01000004 00000001 00000004 00000001
FF800701
3C00 4700 5800 5BF8
3C00 4700 C000 5BF8
FF000701 00000001
// record 2: 3 bit, up scale +2, down scale -1 with saturation cases
00620005 007F0007 00000001 00000007 00000001
ABCD23C5
4D00 0000 4F00 4400 4800
7C00 7E00 0200 8400 4A00 5000 3800
0003E03F 00000001
// record 3: 5 bit values crossing word boundaries
00BD0008 00A20009 00000002 00000009 00000002
4605403F DEAD0045
43C0 3000 4000 3D00 0000 3600 4140 3C00
3C00 3E00 4100 4B00 3400 3300 4380 FC00 4700
C01FA8C4 00000000
00001C03 00000001
// record 4: 1 bit, up scale +7
0027000C 00200006 00000001 00000006 00000001
00000A5C
0000 0000 5800 5800 5800 0000 5800 0000 0000 5800 0000 5800
3C00 0000 4000 3800 BC00 3FFF
00000025 00000001

/* verilog.f */
+incdir+source
source/dq_pkg.sv
source/dq_config.sv
source/bit_extractor.sv
source/dequantizer.sv
source/stream_fifo.sv
source/quantizer.sv
source/bit_packer.sv
source/dequant_quant_top.sv
sim/dq_asserts.sv
sim/dq_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module dq_tb -o dq_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/dq_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* sim/dq_tb.sv */
`timescale 1ns/1ps

module dq_tb import dq_pkg::*; ();

    localparam int MEM_WORDS = 512;

    logic       clk;
    logic       rst_n;
    logic       activate;
    dir_cfg_t   up_cfg;
    dir_cfg_t   down_cfg;
    logic       rcv_valid;
    dma_beat_t  rcv_beat;
    logic       rcv_ready;
    logic       deq_valid;
    half_word_u deq_data;
    logic       deq_ready;
    logic       q_valid;
    half_word_u q_data;
    logic       q_ready;
    logic       trm_valid;
    dma_beat_t  trm_beat;
    logic       trm_ready;

    logic [31:0] tdata [MEM_WORDS];
    logic [15:0] lfsr;
    int          ptr;
    int          cycles = 0;
    int          cycle_limit = 0;

    dequant_quant_top dut0 (
        .clk(clk), .rst_n(rst_n), .activate(activate),
        .up_cfg(up_cfg), .down_cfg(down_cfg),
        .rcv_valid(rcv_valid), .rcv_beat(rcv_beat), .rcv_ready(rcv_ready),
        .deq_valid(deq_valid), .deq_data(deq_data), .deq_ready(deq_ready),
        .q_valid(q_valid), .q_data(q_data), .q_ready(q_ready),
        .trm_valid(trm_valid), .trm_beat(trm_beat), .trm_ready(trm_ready)
    );

    bind dequant_quant_top dq_asserts asserts0 (
        .clk(clk), .rst_n(rst_n), .run(run),
        .deq_valid(deq_valid), .deq_data(deq_data), .deq_ready(deq_ready),
        .trm_valid(trm_valid), .trm_beat(trm_beat), .trm_ready(trm_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic take_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic run_record();
        dir_cfg_t ucfg;
        dir_cfg_t dcfg;
        int       n_rcv;
        int       n_q;
        int       n_beats;
        int       n_up;
        int       rcv_base;
        int       exp_base;
        int       q_base;
        int       beat_base;
        int       rcv_idx;
        int       q_idx;
        int       deq_idx;
        int       trm_idx;
        logic     rcv_fire;
        logic     q_fire;
        ucfg      = tdata[ptr][24:0];
        dcfg      = tdata[ptr+1][24:0];
        n_rcv     = tdata[ptr+2];
        n_q       = tdata[ptr+3];
        n_beats   = tdata[ptr+4];
        n_up      = ucfg.num_values;
        rcv_base  = ptr + 5;
        exp_base  = rcv_base + n_rcv;
        q_base    = exp_base + n_up;
        beat_base = q_base + n_q;
        ptr       = beat_base + 2 * n_beats;
        rcv_idx   = 0;
        q_idx     = 0;
        deq_idx   = 0;
        trm_idx   = 0;
        rcv_fire  = 1'b0;
        q_fire    = 1'b0;
        // drop activate, then a fresh edge with the new settings
        @(negedge clk);
        activate = 1'b0;
        up_cfg   = ucfg;
        down_cfg = dcfg;
        repeat (4) @(negedge clk);
        activate = 1'b1;
        while (deq_idx < n_up || trm_idx < n_beats) begin
            @(negedge clk);
            // transfers decided last falling edge happened at the rising edge
            if (rcv_fire) rcv_idx++;
            if (q_fire) q_idx++;
            rcv_valid     = (rcv_idx < n_rcv);
            rcv_beat.data = rcv_valid ? tdata[rcv_base+rcv_idx] : '0;
            rcv_beat.last = (rcv_idx == n_rcv - 1);
            rcv_fire      = rcv_valid && rcv_ready;
            q_valid       = (q_idx < n_q);
            q_data.raw    = q_valid ? tdata[q_base+q_idx][15:0] : '0;
            q_fire        = q_valid && q_ready;
            deq_ready     = take_bit() | take_bit();
            trm_ready     = take_bit() | take_bit();
            if (deq_valid && deq_ready) begin
                assert (deq_idx < n_up) else
                    fail_run("deq_data delivered more words than configured");
                assert (deq_data.raw == tdata[exp_base+deq_idx][15:0]) else
                    fail_run($sformatf("Mismatch deq_data[%0d]: got %h expected %h", deq_idx,
                             deq_data.raw, tdata[exp_base+deq_idx][15:0]));
                deq_idx++;
            end
            if (trm_valid && trm_ready) begin
                assert (trm_idx < n_beats) else
                    fail_run("trm_beat delivered more words than expected");
                assert (trm_beat.data == tdata[beat_base+2*trm_idx]) else
                    fail_run($sformatf("Mismatch trm_beat.data[%0d]: got %h expected %h",
                             trm_idx, trm_beat.data, tdata[beat_base+2*trm_idx]));
                assert (trm_beat.last == tdata[beat_base+2*trm_idx+1][0]) else
                    fail_run($sformatf("Mismatch trm_beat.last[%0d]: got %h expected %h",
                             trm_idx, trm_beat.last, tdata[beat_base+2*trm_idx+1][0]));
                trm_idx++;
            end
        end
        @(negedge clk);
        if (rcv_fire) rcv_idx++;
        if (q_fire) q_idx++;
        rcv_valid = 1'b0;
        q_valid   = 1'b0;
        deq_ready = 1'b1;
        trm_ready = 1'b1;
        assert (rcv_idx == n_rcv && q_idx == n_q) else
            fail_run("not every input word was accepted by the DUT");
        // nothing extra may follow the expected words
        repeat (6) begin
            @(negedge clk);
            assert (!deq_valid && !trm_valid) else
                fail_run("output valid seen after all expected words");
        end
    endtask

    initial begin
        int n_records;
        int total;
        int p;
        rst_n     = 1'b0;
        activate  = 1'b0;
        up_cfg    = '0;
        down_cfg  = '0;
        rcv_valid = 1'b0;
        rcv_beat  = '0;
        deq_ready = 1'b0;
        q_valid   = 1'b0;
        q_data    = '0;
        trm_ready = 1'b0;
        lfsr      = 16'd52092;
        $readmemh("sim/dq_testdata.hex", tdata);
        n_records = tdata[0];
        total     = 0;
        p         = 1;
        for (int r = 0; r < n_records; r++) begin
            total += tdata[p][15:0] + tdata[p+1][15:0];
            p += 5 + tdata[p+2] + tdata[p][15:0] + tdata[p+3] + 2 * tdata[p+4];
        end
        cycle_limit = 20 * total + 200;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // idle until the first activate
        repeat (8) begin
            @(negedge clk);
            assert (!rcv_ready && !q_ready && !deq_valid && !trm_valid) else
                fail_run("stream outputs active before activate");
        end
        ptr = 1;
        for (int r = 0; r < n_records; r++) begin
            run_record();
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* sim/dq_asserts.sv */
`timescale 1ns/1ps

module dq_asserts import dq_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       run,
    input logic       deq_valid,
    input half_word_u deq_data,
    input logic       deq_ready,
    input logic       trm_valid,
    input dma_beat_t  trm_beat,
    input logic       trm_ready
);

    // accelerator side holds its word until taken
    deq_held: assert property (@(posedge clk) disable iff (!rst_n)
        (deq_valid && !deq_ready) |=> (!run || (deq_valid && $stable(deq_data.raw))))
        else $error("deq_data changed while stalled");

    trm_held: assert property (@(posedge clk) disable iff (!rst_n)
        (trm_valid && !trm_ready) |=> (!run || (trm_valid && $stable(trm_beat))))
        else $error("trm_beat changed while stalled");

    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !run |-> (!deq_valid && !trm_valid))
        else $error("output valid while not running");

    // last only with a beat on offer
    last_valid: assert property (@(posedge clk) disable iff (!rst_n)
        trm_beat.last |-> trm_valid)
        else $error("trm_beat last without trm_valid");

    // the word with last closes the run
    last_final: assert property (@(posedge clk) disable iff (!rst_n)
        (trm_valid && trm_ready && trm_beat.last) |=> !trm_valid)
        else $error("trm_valid after the last word");

endmodule

/* source/dequant_quant_top.sv */
`timescale 1ns/1ps
`include "dq_defs.svh"

module dequant_quant_top import dq_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       activate,
    input  dir_cfg_t   up_cfg,
    input  dir_cfg_t   down_cfg,
    input  logic       rcv_valid,
    input  dma_beat_t  rcv_beat,
    output logic       rcv_ready,
    output logic       deq_valid,
    output half_word_u deq_data,
    input  logic       deq_ready,
    input  logic       q_valid,
    input  half_word_u q_data,
    output logic       q_ready,
    output logic       trm_valid,
    output dma_beat_t  trm_beat,
    input  logic       trm_ready
);

    dir_cfg_t                  up_cfg_r;
    dir_cfg_t                  down_cfg_r;
    logic                      run;
    logic                      ext_valid;
    logic                      ext_ready;
    logic [`DQ_MAX_QWIDTH-1:0] ext_value;
    logic                      dq_valid;
    half_word_u                dq_half;
    logic                      up_af;
    logic                      qz_valid;
    logic [`DQ_MAX_QWIDTH-1:0] qz_value;
    logic                      down_af;
    logic                      pk_valid;
    logic [`DQ_MAX_QWIDTH-1:0] pk_value;
    logic                      pk_ready;

    dq_config cfg0 (
        .clk(clk), .rst_n(rst_n), .activate(activate),
        .up_cfg_in(up_cfg), .down_cfg_in(down_cfg),
        .up_cfg(up_cfg_r), .down_cfg(down_cfg_r), .run(run)
    );

    // upstream: DMA words to half words
    bit_extractor ext0 (
        .clk(clk), .rst_n(rst_n), .run(run), .cfg(up_cfg_r),
        .in_valid(rcv_valid), .in_beat(rcv_beat), .in_ready(rcv_ready),
        .out_valid(ext_valid), .out_value(ext_value), .out_ready(ext_ready)
    );

    // pipeline cannot stall, so the FIFO level throttles the source
    assign ext_ready = ~up_af;

    dequantizer deq0 (
        .clk(clk), .rst_n(rst_n), .run(run), .cfg(up_cfg_r),
        .in_valid(ext_valid & ext_ready), .in_value(ext_value),
        .out_valid(dq_valid), .out_half(dq_half)
    );

    stream_fifo #(.WIDTH(16), .DEPTH(`DQ_FIFO_DEPTH)) up_fifo (
        .clk(clk), .rst_n(rst_n), .run(run),
        .wr_valid(dq_valid), .wr_data(dq_half.raw),
        .rd_valid(deq_valid), .rd_data(deq_data.raw), .rd_ready(deq_ready),
        .almost_full(up_af)
    );

    // downstream: half words to DMA words
    assign q_ready = ~down_af;

    quantizer qnt0 (
        .clk(clk), .rst_n(rst_n), .run(run), .cfg(down_cfg_r),
        .in_valid(q_valid & q_ready), .in_half(q_data),
        .out_valid(qz_valid), .out_value(qz_value)
    );

    stream_fifo #(.WIDTH(`DQ_MAX_QWIDTH), .DEPTH(`DQ_FIFO_DEPTH)) down_fifo (
        .clk(clk), .rst_n(rst_n), .run(run),
        .wr_valid(qz_valid), .wr_data(qz_value),
        .rd_valid(pk_valid), .rd_data(pk_value), .rd_ready(pk_ready),
        .almost_full(down_af)
    );

    bit_packer pack0 (
        .clk(clk), .rst_n(rst_n), .run(run), .cfg(down_cfg_r),
        .in_valid(pk_valid), .in_value(pk_value), .in_ready(pk_ready),
        .out_valid(trm_valid), .out_beat(trm_beat), .out_ready(trm_ready)
    );

endmodule

/* source/bit_packer.sv */
`timescale 1ns/1ps
`include "dq_defs.svh"

module bit_packer import dq_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run,
    input  dir_cfg_t                  cfg,
    input  logic                      in_valid,
    input  logic [`DQ_MAX_QWIDTH-1:0] in_value,
    output logic                      in_ready,
    output logic                      out_valid,
    output dma_beat_t                 out_beat,
    input  logic                      out_ready
);

    localparam int ACC_W = `DQ_DMA_WIDTH + `DQ_MAX_QWIDTH;

    logic [ACC_W-1:0]           acc;
    logic [ACC_W-1:0]           acc_next;
    logic [5:0]                 fill;
    logic [5:0]                 fill_next;
    logic [`DQ_COUNT_WIDTH-1:0] received;
    logic                       all_in;
    logic                       flush;
    logic                       take;
    logic                       push;
    logic                       last_word;

    assign all_in   = (received == cfg.num_values);
    assign in_ready = run && !all_in && (fill < 6'd32);
    assign push     = in_valid && in_ready;

    // full word ready, or the tail after the final value
    assign flush     = run && ((fill >= 6'd32) || (all_in && (fill != '0)));
    assign take      = flush && (!out_valid || out_ready);
    assign last_word = all_in && (fill <= 6'd32);

    always_comb begin
        acc_next  = acc;
        fill_next = fill;
        if (take) begin
            acc_next  = acc >> `DQ_DMA_WIDTH;
            fill_next = (fill >= 6'd32) ? fill - 6'd32 : '0;
        end
        if (push) begin
            acc_next  = acc_next | ({{`DQ_DMA_WIDTH{1'b0}}, in_value} << fill_next);
            fill_next = fill_next + {2'd0, cfg.bitwidth};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill      <= '0;
            received  <= '0;
            out_valid <= 1'b0;
        end else if (!run) begin
            fill      <= '0;
            received  <= '0;
            out_valid <= 1'b0;
        end else begin
            fill <= fill_next;
            if (push) begin
                received <= received + 1'b1;
            end
            if (take) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // shifts keep unused high bits at zero
    always_ff @(posedge clk) begin
        acc <= run ? acc_next : '0;
        if (take) begin
            out_beat.data <= acc[`DQ_DMA_WIDTH-1:0];
            out_beat.last <= last_word;
        end else if (!run || out_ready) begin
            // last only marks a beat that is on offer
            out_beat.last <= 1'b0;
        end
    end

endmodule

/* source/quantizer.sv */
`timescale 1ns/1ps
`include "dq_defs.svh"

module quantizer import dq_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run,
    input  dir_cfg_t                  cfg,
    input  logic                      in_valid,
    input  half_word_u                in_half,
    output logic                      out_valid,
    output logic [`DQ_MAX_QWIDTH-1:0] out_value
);

    logic                      s1_valid;
    logic                      s1_sign;
    logic                      s1_zero;
    logic                      s1_inf;
    logic [10:0]               s1_mant;
    logic signed [6:0]         s1_exp;
    logic signed [6:0]         exp_in;
    logic [`DQ_MAX_QWIDTH:0]   max_val;
    logic [3:0]                shamt;
    logic [10:0]               shifted;
    logic [`DQ_MAX_QWIDTH-1:0] q_next;

    // stage 1: unbiased exponent plus scale
    assign exp_in  = $signed({2'd0, in_half.f.exponent}) - 7'sd15
                     + 7'($signed(cfg.scale_exp));
    assign max_val = ({{`DQ_MAX_QWIDTH{1'b0}}, 1'b1} << cfg.bitwidth) - 1'b1;

    // stage 2: only exponents 0..bitwidth-1 reach the shift
    assign shamt   = 4'd10 - {1'b0, s1_exp[2:0]};
    assign shifted = s1_mant >> shamt;

    always_comb begin
        if (s1_sign || s1_zero) begin
            q_next = '0;
        end else if (s1_inf || (s1_exp >= $signed({3'd0, cfg.bitwidth}))) begin
            q_next = max_val[`DQ_MAX_QWIDTH-1:0];
        end else if (s1_exp < 0) begin
            // magnitude below one truncates to zero
            q_next = '0;
        end else begin
            q_next = shifted[`DQ_MAX_QWIDTH-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= run && in_valid;
            out_valid <= run && s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_sign   <= in_half.f.sign;
        s1_zero   <= (in_half.f.exponent == 5'd0);
        s1_inf    <= (in_half.f.exponent == 5'd31);
        s1_mant   <= {1'b1, in_half.f.fraction};
        s1_exp    <= exp_in;
        out_value <= q_next;
    end

endmodule

/* source/stream_fifo.sv */
`timescale 1ns/1ps
`include "dq_defs.svh"

module stream_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             run,
    input  logic             wr_valid,
    input  logic [WIDTH-1:0] wr_data,
    output logic             rd_valid,
    output logic [WIDTH-1:0] rd_data,
    input  logic             rd_ready,
    output logic             almost_full
);

    localparam int PTR_W    = $clog2(DEPTH);
    // room left for everything still in the pipeline
    localparam int AF_LEVEL = DEPTH - (`DQ_PIPE_LEN + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_next;
    logic             rd_fire;

    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign rd_fire  = rd_valid && rd_ready;

    always_comb begin
        count_next = count;
        if (wr_valid) begin
            count_next = count_next + 1'b1;
        end
        if (rd_fire) begin
            count_next = count_next - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b1;
        end else if (!run) begin
            // reads as full while idle so nothing is pushed
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b1;
        end else begin
            wr_ptr      <= wr_valid ? wr_ptr + 1'b1 : wr_ptr;
            rd_ptr      <= rd_fire ? rd_ptr + 1'b1 : rd_ptr;
            count       <= count_next;
            almost_full <= (count_next >= AF_LEVEL);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* source/dequantizer.sv */
`timescale 1ns/1ps
`include "dq_defs.svh"

module dequantizer import dq_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run,
    input  dir_cfg_t                  cfg,
    input  logic                      in_valid,
    input  logic [`DQ_MAX_QWIDTH-1:0] in_value,
    output logic                      out_valid,
    output half_word_u                out_half
);

    logic                      s1_valid;
    logic [`DQ_MAX_QWIDTH-1:0] s1_value;
    logic [2:0]                s1_pos;
    logic signed [6:0]         exp_sum;
    logic [17:0]               frac_wide;
    half_word_u                half_next;

    function automatic logic [2:0] lead_pos(input logic [`DQ_MAX_QWIDTH-1:0] v);
        logic [2:0] p;
        p = '0;
        for (int i = 0; i < `DQ_MAX_QWIDTH; i++) begin
            if (v[i]) begin
                p = 3'(i);
            end
        end
        return p;
    endfunction

    // stage 2: exponent from leading one and scale
    always_comb begin
        exp_sum   = 7'sd15 + $signed({4'd0, s1_pos}) + 7'($signed(cfg.scale_exp));
        // bits below the leading one, left-aligned in the fraction
        frac_wide = {10'd0, s1_value} << (4'd10 - {1'b0, s1_pos});
        half_next.f.sign     = 1'b0;
        half_next.f.exponent = exp_sum[4:0];
        half_next.f.fraction = frac_wide[9:0];
        if (s1_value == '0) begin
            half_next.raw = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= run && in_valid;
            out_valid <= run && s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_value <= in_value;
        s1_pos   <= lead_pos(in_value);
        out_half <= half_next;
    end

endmodule

/* source/bit_extractor.sv */
`timescale 1ns/1ps
`include "dq_defs.svh"

module bit_extractor import dq_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run,
    input  dir_cfg_t                  cfg,
    input  logic                      in_valid,
    input  dma_beat_t                 in_beat,
    output logic                      in_ready,
    output logic                      out_valid,
    output logic [`DQ_MAX_QWIDTH-1:0] out_value,
    input  logic                      out_ready
);

    localparam int RES_W = 2 * `DQ_DMA_WIDTH;

    logic [RES_W-1:0]             reservoir;
    logic [RES_W-1:0]             res_next;
    logic [6:0]                   fill;
    logic [6:0]                   fill_next;
    logic [`DQ_COUNT_WIDTH-1:0]   emitted;
    logic [`DQ_COUNT_WIDTH-1:0]   remaining;
    logic [`DQ_COUNT_WIDTH+3:0]   bits_needed;
    logic [`DQ_MAX_QWIDTH:0]      mask;
    logic                         push;
    logic                         pop;

    assign remaining   = cfg.num_values - emitted;
    assign bits_needed = remaining * cfg.bitwidth;
    assign mask        = ({{`DQ_MAX_QWIDTH{1'b0}}, 1'b1} << cfg.bitwidth) - 1'b1;

    // a new word only if it fits and the values still need bits
    assign in_ready  = run && (fill <= 7'd32) && ({13'd0, fill} < bits_needed);
    assign out_valid = run && (remaining != '0) && (fill >= {3'd0, cfg.bitwidth});
    assign out_value = reservoir[`DQ_MAX_QWIDTH-1:0] & mask[`DQ_MAX_QWIDTH-1:0];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_comb begin
        res_next  = reservoir;
        fill_next = fill;
        if (pop) begin
            res_next  = reservoir >> cfg.bitwidth;
            fill_next = fill - {3'd0, cfg.bitwidth};
        end
        // new word lands right above the bits still held
        if (push) begin
            res_next  = res_next | ({{`DQ_DMA_WIDTH{1'b0}}, in_beat.data} << fill_next);
            fill_next = fill_next + 7'd32;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill    <= '0;
            emitted <= '0;
        end else if (!run) begin
            fill    <= '0;
            emitted <= '0;
        end else begin
            fill <= fill_next;
            if (pop) begin
                emitted <= emitted + 1'b1;
            end
        end
    end

    // bits above fill must stay zero for the OR insert
    always_ff @(posedge clk) begin
        reservoir <= run ? res_next : '0;
    end

endmodule

/* source/dq_config.sv */
`timescale 1ns/1ps

module dq_config import dq_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     activate,
    input  dir_cfg_t up_cfg_in,
    input  dir_cfg_t down_cfg_in,
    output dir_cfg_t up_cfg,
    output dir_cfg_t down_cfg,
    output logic     run
);

    logic activate_d;
    logic activate_rise;

    assign activate_rise = activate && !activate_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            activate_d <= 1'b0;
            run        <= 1'b0;
        end else begin
            activate_d <= activate;
            // run follows activate, raised only by a fresh edge
            if (!activate) begin
                run <= 1'b0;
            end else if (activate_rise) begin
                run <= 1'b1;
            end
        end
    end

    // both register sets taken on the same edge
    always_ff @(posedge clk) begin
        if (activate_rise) begin
            up_cfg   <= up_cfg_in;
            down_cfg <= down_cfg_in;
        end
    end

endmodule

/* source/dq_pkg.sv */
`include "dq_defs.svh"

package dq_pkg;

    // one direction's register set
    typedef struct packed {
        logic [3:0]                     bitwidth;
        logic signed [4:0]              scale_exp;
        logic [`DQ_COUNT_WIDTH-1:0]     num_values;
    } dir_cfg_t;

    // IEEE half-precision fields
    typedef struct packed {
        logic       sign;
        logic [4:0] exponent;
        logic [9:0] fraction;
    } half_fields_t;

    // half word, either as raw bits or as fields
    typedef union packed {
        logic [15:0]  raw;
        half_fields_t f;
    } half_word_u;

    typedef struct packed {
        logic [`DQ_DMA_WIDTH-1:0] data;
        logic                     last;
    } dma_beat_t;

endpackage

/* source/dq_defs.svh */
`ifndef DQ_DEFS_SVH
`define DQ_DEFS_SVH

// width of one DMA word
`define DQ_DMA_WIDTH 32

// widest quantized value
`define DQ_MAX_QWIDTH 8

// entries per stream FIFO
`define DQ_FIFO_DEPTH 32

// latency of the dequantizer and the quantizer
`define DQ_PIPE_LEN 2

// width of the per-direction value count
`define DQ_COUNT_WIDTH 16

`endif
